// File: logic/accel_pkg.sv
/* sensor-side constants for the adxl355 channels and the frame layout
   command bytes use the adxl355 read encoding (reg << 1) | 1 */
package accel_pkg;

  // channel count and tag width, CH_W must cover NUM_SENSORS
  localparam int NUM_SENSORS = 4;
  localparam int CH_W        = 2;

  // len field counts the command byte too, so at most 15 bytes per frame
  localparam int LEN_W = 4;

  // read commands
  localparam logic [7:0] CMD_READ_XYZ = 8'h11; // xdata3 at 0x08, auto-increment
  localparam logic [7:0] CMD_READ_ID  = 8'h01; // devid_ad at 0x00

  // xyz frame layout
  //   byte 0     command, echo discarded
  //   bytes 1-3  x, msb first, byte 3 holds the 4 lsbs of 20 bits
  //   bytes 4-6  y
  //   bytes 7-9  z
  // the 16-bit view drops the third byte of each axis
  localparam logic [LEN_W-1:0] XYZ_LEN = 4'd10;

endpackage

// File: logic/spi_pkg.sv
/* bus-side constants and the reader phase encoding
   SYNC_DIV must exceed a full 15-byte frame (244 enables) */
package spi_pkg;

  // clk cycles per clk_en pulse, sclk runs at half the enable rate
  localparam int EN_DIV = 4;

  // clk_en pulses per sync pulse, sets the sample rate
  localparam int SYNC_DIV = 256;

  // frame index width, holds len*16+4 for any len
  localparam int IDX_W = 8;

  // where the reader sits within a frame
  typedef enum logic [1:0] {
    IDLE,     // waiting for sync, pins may be in direct mode
    SELECT,   // csn going low, sclk not yet running
    SHIFT,    // sclk toggling, bytes moving
    DESELECT  // sclk stopped, csn about to rise
  } reader_phase_e;

endpackage

// File: logic/sample_if.sv
/* byte strobes from one reader channel to the merge block
   all strobes are single clk wide and carry no handshake */
interface sample_if;

  logic [7:0] data; // received byte, valid while any strobe is high
  logic       wr;   // every data byte
  logic       wr16; // only bytes of the 16-bit samples
  logic       x;    // first byte of an xyz group, with wr

  modport writer (
    output data,
    output wr,
    output wr16,
    output x
  );

  modport reader (
    input data,
    input wr,
    input wr16,
    input x
  );

endinterface

// File: logic/sample_pacer.sv
/* shared timing for all reader channels
   clk_en is one clk every EN_DIV, sync rides on every SYNC_DIV-th clk_en
   first sync comes SYNC_DIV enables after reset */
module sample_pacer (
  input  logic clk,
  input  logic rst_n,
  output logic clk_en,
  output logic sync
);

  typedef logic [$clog2(spi_pkg::EN_DIV)-1:0]   en_cnt_t;
  typedef logic [$clog2(spi_pkg::SYNC_DIV)-1:0] sync_cnt_t;

  en_cnt_t   en_cnt;   // clk cycles within one enable period
  sync_cnt_t sync_cnt; // enables within one sample period
  logic      en_last;
  logic      sync_last;

  assign en_last   = (en_cnt == en_cnt_t'(spi_pkg::EN_DIV - 1));
  assign sync_last = (sync_cnt == sync_cnt_t'(spi_pkg::SYNC_DIV - 1));

  // enable prescaler
  always_ff @(posedge clk)
  begin
    if (!rst_n)
    begin
      en_cnt <= '0;
    end
    else if (en_last)
    begin
      en_cnt <= '0;
    end
    else
    begin
      en_cnt <= en_cnt + 1'b1;
    end
  end

  // sample period counter, steps once per enable
  always_ff @(posedge clk)
  begin
    if (!rst_n)
    begin
      sync_cnt <= '0;
    end
    else if (en_last)
    begin
      sync_cnt <= sync_last ? '0 : sync_cnt + 1'b1;
    end
  end

  // registered pulses, sync always lands on a clk_en cycle
  always_ff @(posedge clk)
  begin
    if (!rst_n)
    begin
      clk_en <= 1'b0;
      sync   <= 1'b0;
    end
    else
    begin
      clk_en <= en_last;
      sync   <= en_last && sync_last; // all channels start in lockstep
    end
  end

endmodule

// File: logic/adxl355_reader.sv
/* one adxl355 channel, spi mode 0, sclk = clk_en/2, msb first
   a frame of len bytes starts on sync only when idle and not direct
   direct mode switches only between frames, no miso mux for the host */
module adxl355_reader (
  input  logic                        clk,
  input  logic                        rst_n,
  input  logic                        clk_en,
  input  logic                        sync,
  input  logic [7:0]                  cmd,
  input  logic [accel_pkg::LEN_W-1:0] len,
  input  logic                        direct,
  input  logic                        direct_mosi,
  input  logic                        direct_sclk,
  input  logic                        direct_csn,
  input  logic                        adxl_miso,
  output logic                        adxl_mosi,
  output logic                        adxl_sclk,
  output logic                        adxl_csn,
  sample_if.writer                    smp
);

  logic [7:0]                  cmd_q;        // command replayed each frame
  logic [accel_pkg::LEN_W-1:0] len_q;        // byte count incl. command
  logic [spi_pkg::IDX_W-1:0]   idx;          // half sclk periods since sync
  logic [spi_pkg::IDX_W-1:0]   idx_end;
  logic [spi_pkg::IDX_W-1:0]   idx_deselect;
  logic [spi_pkg::IDX_W-1:0]   idx_sclk_off;
  spi_pkg::reader_phase_e      phase;
  logic                        r_direct;     // host owns the pins
  logic                        r_csn;
  logic                        r_sclk_en;
  logic                        r_sclk;
  logic [7:0]                  r_mosi;
  logic [7:0]                  r_miso;
  logic [7:0]                  r_shift;      // one-hot, bit 7 marks a byte boundary
  logic [accel_pkg::LEN_W-1:0] byte_num;     // 0 is the command echo
  logic                        skip16;
  logic                        cap;
  logic                        start;

  // 16 enables per byte, frame ends at len*16+4
  assign idx_end      = {len_q, 4'h4};
  assign idx_deselect = {len_q, 4'h3};
  assign idx_sclk_off = {len_q, 4'h2};

  always_comb
  begin
    if (idx == idx_end)
      phase = spi_pkg::IDLE;
    else if (idx < spi_pkg::IDX_W'(2))
      phase = spi_pkg::SELECT;
    else if (idx < idx_sclk_off)
      phase = spi_pkg::SHIFT;
    else
      phase = spi_pkg::DESELECT;
  end

  assign start = (phase == spi_pkg::IDLE) && sync && !r_direct;

  // byte k completes at idx 16k+18
  assign byte_num = idx[spi_pkg::IDX_W-1:4] - 4'd1;
  assign skip16   = (byte_num == 4'd3) || (byte_num == 4'd6) || (byte_num == 4'd9);
  assign cap      = clk_en && !idx[0] && r_shift[7] && r_sclk_en;

  // frame index, parks at idx_end between frames
  always_ff @(posedge clk)
  begin
    if (!rst_n)
    begin
      idx   <= {accel_pkg::XYZ_LEN, 4'h4};
      cmd_q <= accel_pkg::CMD_READ_ID;
      len_q <= accel_pkg::XYZ_LEN;
    end
    else if (start)
    begin
      idx   <= '0;
      cmd_q <= cmd;
      len_q <= len;
    end
    else if (clk_en && phase != spi_pkg::IDLE)
    begin
      idx <= idx + 1'b1;
    end
  end

  // chip select, clock gate and direct select
  always_ff @(posedge clk)
  begin
    if (!rst_n)
    begin
      r_csn     <= 1'b1;
      r_sclk_en <= 1'b0;
      r_sclk    <= 1'b0;
      r_direct  <= 1'b0;
    end
    else if (clk_en)
    begin
      if (idx == spi_pkg::IDX_W'(1))
        r_csn <= 1'b0;
      else if (idx == idx_deselect)
        r_csn <= 1'b1;
      if (idx == spi_pkg::IDX_W'(2))
        r_sclk_en <= 1'b1;
      else if (idx == idx_sclk_off)
        r_sclk_en <= 1'b0;
      r_sclk <= r_sclk_en ? idx[0] : 1'b0; // rises on odd idx
      // take direct at frame end, or leave it on an idle sync
      if (idx == idx_deselect || (phase == spi_pkg::IDLE && sync && r_direct))
        r_direct <= direct;
    end
  end

  // mosi and boundary marker shift on the falling edge
  always_ff @(posedge clk)
  begin
    if (!rst_n)
    begin
      r_mosi  <= 8'h00;
      r_shift <= 8'h01;
    end
    else if (clk_en && !idx[0])
    begin
      r_mosi  <= (idx == spi_pkg::IDX_W'(2)) ? cmd_q : {r_mosi[6:0], 1'b0};
      r_shift <= (idx == spi_pkg::IDX_W'(2)) ? 8'h01 : {r_shift[6:0], r_shift[7]};
    end
  end

  // miso sampled at the end of the high sclk phase
  always_ff @(posedge clk)
  begin
    if (clk_en && !idx[0])
      r_miso <= {r_miso[6:0], adxl_miso};
  end

  // strobes last one clk, command echo never written
  always_ff @(posedge clk)
  begin
    if (!rst_n)
    begin
      smp.wr   <= 1'b0;
      smp.wr16 <= 1'b0;
      smp.x    <= 1'b0;
    end
    else
    begin
      smp.wr   <= cap && byte_num != '0;
      smp.wr16 <= cap && byte_num != '0 && !skip16;
      smp.x    <= cap && byte_num == 4'd1;
    end
  end

  always_ff @(posedge clk)
  begin
    if (cap)
      smp.data <= {r_miso[6:0], adxl_miso}; // held until the next byte
  end

  // host pins take over while r_direct is set
  assign adxl_csn  = r_direct ? direct_csn  : r_csn;
  assign adxl_sclk = r_direct ? direct_sclk : r_sclk;
  assign adxl_mosi = r_direct ? direct_mosi : r_mosi[7];

endmodule

// File: logic/sample_merge.sv
/* merges all channel strobes into one tagged byte stream, no back-pressure
   two-entry queue per channel, rotating pointer serves one channel per clk
   a byte leaves at most NUM_SENSORS+1 clk after its strobe */
module sample_merge (
  input  logic                       clk,
  input  logic                       rst_n,
  input  logic                       wide16, // 1: 16-bit bytes only, 0: every data byte
  sample_if.reader                   ch [accel_pkg::NUM_SENSORS],
  output logic                       stream_valid,
  output logic [7:0]                 stream_data,
  output logic [accel_pkg::CH_W-1:0] stream_chan,
  output logic                       stream_x
);

  logic [accel_pkg::CH_W-1:0]            rr;         // channel served this clk
  wire  [accel_pkg::NUM_SENSORS-1:0]      q_nonempty;
  wire  [accel_pkg::NUM_SENSORS-1:0][7:0] head_data;
  wire  [accel_pkg::NUM_SENSORS-1:0]      head_x;

  for (genvar i = 0; i < accel_pkg::NUM_SENSORS; i++)
  begin : gen_queue
    logic [7:0] q_data [2];
    logic [1:0] q_xb;
    logic [1:0] cnt;  // 0, 1 or 2 entries
    logic       wp;
    logic       rp;
    wire        push = wide16 ? ch[i].wr16 : ch[i].wr;
    wire        pop  = (rr == accel_pkg::CH_W'(i)) && (cnt != 2'd0);

    always_ff @(posedge clk)
    begin
      if (!rst_n)
      begin
        cnt <= 2'd0;
        wp  <= 1'b0;
        rp  <= 1'b0;
      end
      else
      begin
        if (push)
          wp <= ~wp;
        if (pop)
          rp <= ~rp;
        case ({push, pop})
          2'b10:   cnt <= cnt + 2'd1;
          2'b01:   cnt <= cnt - 2'd1;
          default: cnt <= cnt; // both or neither
        endcase
      end
    end

    always_ff @(posedge clk)
    begin
      if (push)
      begin
        q_data[wp] <= ch[i].data;
        q_xb[wp]   <= ch[i].x;
      end
    end

    assign q_nonempty[i] = (cnt != 2'd0);
    assign head_data[i]  = q_data[rp];
    assign head_x[i]     = q_xb[rp];
  end

  // pointer rotates every clk whether or not the channel has data
  always_ff @(posedge clk)
  begin
    if (!rst_n)
    begin
      rr           <= '0;
      stream_valid <= 1'b0;
    end
    else
    begin
      stream_valid <= q_nonempty[rr];
      if (rr == accel_pkg::CH_W'(accel_pkg::NUM_SENSORS - 1))
        rr <= '0;
      else
        rr <= rr + 1'b1;
    end
  end

  always_ff @(posedge clk)
  begin
    stream_data <= head_data[rr];
    stream_chan <= rr;
    stream_x    <= q_nonempty[rr] && head_x[rr]; // low when nothing leaves
  end

endmodule

// File: logic/accel_array.sv
/* top level, NUM_SENSORS adxl355 readers sharing one pacer
   pin vectors are indexed by channel, host reads adxl_miso directly
   stream carries no handshake, the buffer must take every valid byte */
module accel_array (
  input  logic                              clk,
  input  logic                              rst_n,
  input  logic [7:0]                        cmd,
  input  logic [accel_pkg::LEN_W-1:0]       len,
  input  logic                              wide16,
  input  logic [accel_pkg::NUM_SENSORS-1:0] direct,
  input  logic [accel_pkg::NUM_SENSORS-1:0] direct_mosi,
  input  logic [accel_pkg::NUM_SENSORS-1:0] direct_sclk,
  input  logic [accel_pkg::NUM_SENSORS-1:0] direct_csn,
  input  logic [accel_pkg::NUM_SENSORS-1:0] adxl_miso,
  output logic [accel_pkg::NUM_SENSORS-1:0] adxl_mosi,
  output logic [accel_pkg::NUM_SENSORS-1:0] adxl_sclk,
  output logic [accel_pkg::NUM_SENSORS-1:0] adxl_csn,
  output logic                              stream_valid,
  output logic [7:0]                        stream_data,
  output logic [accel_pkg::CH_W-1:0]        stream_chan,
  output logic                              stream_x
);

  logic clk_en;
  logic sync;

  sample_if smp_if [accel_pkg::NUM_SENSORS] (); // one per channel

  sample_pacer u_pacer (
    .clk    (clk),
    .rst_n  (rst_n),
    .clk_en (clk_en),
    .sync   (sync)
  );

  for (genvar i = 0; i < accel_pkg::NUM_SENSORS; i++)
  begin : gen_ch
    adxl355_reader u_reader (
      .clk         (clk),
      .rst_n       (rst_n),
      .clk_en      (clk_en),
      .sync        (sync),
      .cmd         (cmd),
      .len         (len),
      .direct      (direct[i]),
      .direct_mosi (direct_mosi[i]),
      .direct_sclk (direct_sclk[i]),
      .direct_csn  (direct_csn[i]),
      .adxl_miso   (adxl_miso[i]),
      .adxl_mosi   (adxl_mosi[i]),
      .adxl_sclk   (adxl_sclk[i]),
      .adxl_csn    (adxl_csn[i]),
      .smp         (smp_if[i])
    );
  end

  sample_merge u_merge (
    .clk          (clk),
    .rst_n        (rst_n),
    .wide16       (wide16),
    .ch           (smp_if),
    .stream_valid (stream_valid),
    .stream_data  (stream_data),
    .stream_chan  (stream_chan),
    .stream_x     (stream_x)
  );

endmodule

// File: bench/adxl355_model.sv
/* spi mode 0 slave, returns base+k for byte k of each frame (k=0 under the command)
   reports the command byte and the byte count seen between csn edges */
module adxl355_model (
  input  logic       csn,
  input  logic       sclk,
  input  logic       mosi,
  input  logic [7:0] base,
  output logic       miso,
  output logic [7:0] last_cmd,
  output logic [7:0] last_count,
  output int         frames
);
  timeunit 1ns;
  timeprecision 100ps;

  logic [7:0] rx;
  logic [7:0] tx;
  logic [7:0] cmd_seen;
  int         bit_cnt;
  int         byte_cnt;
  logic       active; // ignores the x to 1 edge of csn at reset

  initial
  begin
    miso       = 1'b0;
    last_cmd   = 8'h00;
    last_count = 8'h00;
    frames     = 0;
    active     = 1'b0;
  end

  always @(negedge csn)
  begin
    active   = 1'b1;
    bit_cnt  = 0;
    byte_cnt = 0;
    tx       = base;
    miso     = tx[7]; // first bit out before the first rising sclk
  end

  always @(posedge sclk)
  begin
    if (csn === 1'b0)
    begin
      rx = {rx[6:0], mosi};
      bit_cnt++;
      if (bit_cnt == 8)
      begin
        if (byte_cnt == 0)
          cmd_seen = rx;
        byte_cnt++;
        bit_cnt = 0;
      end
    end
  end

  // next bit goes out on the falling edge
  always @(negedge sclk)
  begin
    if (csn === 1'b0)
    begin
      if (bit_cnt == 0)
      begin
        tx   = base + byte_cnt[7:0];
        miso = tx[7];
      end
      else
        miso = tx[7-bit_cnt];
    end
  end

  always @(posedge csn)
  begin
    if (active)
    begin
      last_cmd   = cmd_seen;
      last_count = byte_cnt[7:0];
      frames++;
      active     = 1'b0;
    end
  end

endmodule

// File: bench/accel_array_chk.sv
/* spi pin and stream assertions, bound into accel_array
   direct history is 8 clk deep so a tail byte of the last frame may still leave */
module accel_array_chk (
  input logic                              clk,
  input logic                              rst_n,
  input logic                              sync,
  input logic [accel_pkg::NUM_SENSORS-1:0] adxl_csn,
  input logic [accel_pkg::NUM_SENSORS-1:0] adxl_sclk,
  input logic [accel_pkg::NUM_SENSORS-1:0] r_direct,
  input logic                              stream_valid,
  input logic [accel_pkg::CH_W-1:0]        stream_chan
);
  timeunit 1ns;
  timeprecision 100ps;

  logic                                   seen_sync; // first sync has passed
  logic [7:0][accel_pkg::NUM_SENSORS-1:0] dir_hist;  // [7] is 8 clk old

  always_ff @(posedge clk)
  begin
    if (!rst_n)
    begin
      seen_sync <= 1'b0;
      dir_hist  <= '0;
    end
    else
    begin
      seen_sync <= seen_sync | sync;
      dir_hist  <= {dir_hist[6:0], r_direct};
    end
  end

  a_sclk_idle: assert property (@(posedge clk) disable iff (!rst_n)
    (adxl_sclk & adxl_csn) == '0)
    else $error("sclk high while csn high");

  a_csn_before_sync: assert property (@(posedge clk) disable iff (!rst_n)
    !seen_sync |-> &adxl_csn)
    else $error("csn low before the first sync");

  a_no_stream_direct: assert property (@(posedge clk) disable iff (!rst_n)
    stream_valid |-> !dir_hist[7][stream_chan])
    else $error("stream byte from a channel in direct mode");

endmodule

bind accel_array accel_array_chk u_chk (
  .clk          (clk),
  .rst_n        (rst_n),
  .sync         (sync),
  .adxl_csn     (adxl_csn),
  .adxl_sclk    (adxl_sclk),
  .r_direct     ({gen_ch[3].u_reader.r_direct, gen_ch[2].u_reader.r_direct,
                  gen_ch[1].u_reader.r_direct, gen_ch[0].u_reader.r_direct}),
  .stream_valid (stream_valid),
  .stream_chan  (stream_chan)
);

// File: bench/tb_accel_array.sv
/* random frames on all channels from a fixed xorshift seed, checked against a queue model
   host pins move only around the pin check and are released before the next sync */
module tb_accel_array;
  timeunit 1ns;
  timeprecision 100ps;

  localparam int N      = accel_pkg::NUM_SENSORS;
  localparam int CW     = accel_pkg::CH_W;
  localparam int ROUNDS = 24;

  logic                         clk = 1'b0;
  logic                         rst_n;
  logic [7:0]                   cmd;
  logic [accel_pkg::LEN_W-1:0]  len;
  logic                         wide16;
  logic [N-1:0]                 direct;
  logic [N-1:0]                 direct_mosi;
  logic [N-1:0]                 direct_sclk;
  logic [N-1:0]                 direct_csn;
  wire  [N-1:0]                 adxl_miso; // driven by the sensor models
  wire  [N-1:0]                 adxl_mosi;
  wire  [N-1:0]                 adxl_sclk;
  wire  [N-1:0]                 adxl_csn;
  wire                          stream_valid;
  wire  [7:0]                   stream_data;
  wire  [CW-1:0]                stream_chan;
  wire                          stream_x;
  wire  [7:0]                   model_cmd [N];
  wire  [7:0]                   model_count [N];
  wire  [31:0]                  model_frames [N];

  logic [7:0]                   base [N];  // per-channel byte pattern
  logic [31:0]                  rng;
  logic [N-1:0]                 ds;        // predicted direct select per channel
  logic [N-1:0]                 framing;   // channel started a frame at this sync
  int                           frames_exp [N];
  logic [7:0]                   cmd_at_sync;
  logic [accel_pkg::LEN_W-1:0]  len_at_sync;
  logic [CW+8:0]                exp_q [$]; // {chan, x, data}

  always #20 clk = ~clk;

  accel_array i_dut (
    .clk          (clk),
    .rst_n        (rst_n),
    .cmd          (cmd),
    .len          (len),
    .wide16       (wide16),
    .direct       (direct),
    .direct_mosi  (direct_mosi),
    .direct_sclk  (direct_sclk),
    .direct_csn   (direct_csn),
    .adxl_miso    (adxl_miso),
    .adxl_mosi    (adxl_mosi),
    .adxl_sclk    (adxl_sclk),
    .adxl_csn     (adxl_csn),
    .stream_valid (stream_valid),
    .stream_data  (stream_data),
    .stream_chan  (stream_chan),
    .stream_x     (stream_x)
  );

  for (genvar i = 0; i < N; i++)
  begin : gen_model
    adxl355_model u_model (
      .csn        (adxl_csn[i]),
      .sclk       (adxl_sclk[i]),
      .mosi       (adxl_mosi[i]),
      .base       (base[i]),
      .miso       (adxl_miso[i]),
      .last_cmd   (model_cmd[i]),
      .last_count (model_count[i]),
      .frames     (model_frames[i])
    );
  end

  function automatic logic [31:0] xorshift(input logic [31:0] s);
    logic [31:0] v;
    v = s;
    v = v ^ (v << 13);
    v = v ^ (v >> 17);
    v = v ^ (v << 5);
    return v;
  endfunction

  task automatic abort_run();
    $display("Regression failed");
    $fatal(1);
  endtask

  task automatic check_byte(input logic [7:0] exp_d, input logic exp_x,
                            input logic [7:0] act_d, input logic act_x);
    if (act_d !== exp_d)
    begin
      $display("Error stream_data expected 0x%02h actual 0x%02h", exp_d, act_d);
      abort_run();
    end
    else if (act_x !== exp_x)
    begin
      $display("Error stream_x expected 0x%0h actual 0x%0h", exp_x, act_x);
      abort_run();
    end
  endtask

  task automatic check_pin(input string name, input logic [N-1:0] exp_v,
                           input logic [N-1:0] act_v);
    if (act_v !== exp_v)
    begin
      $display("Error %s expected 0x%0h actual 0x%0h", name, exp_v, act_v);
      abort_run();
    end
  endtask

  // what the sensor saw under csn in one frame
  task automatic check_frame(input int c, input logic [7:0] act_cmd,
                             input logic [7:0] act_count);
    if (act_cmd !== cmd_at_sync)
    begin
      $display("Error model_cmd[%0d] expected 0x%02h actual 0x%02h", c, cmd_at_sync, act_cmd);
      abort_run();
    end
    else if (act_count !== 8'(len_at_sync))
    begin
      $display("Error model_count[%0d] expected 0x%02h actual 0x%02h",
               c, 8'(len_at_sync), act_count);
      abort_run();
    end
  endtask

  task automatic wait_sync();
    int t;
    t = 0;
    do
    begin
      @(negedge clk);
      t++;
    end
    while (i_dut.sync !== 1'b1 && t < 1200);
    if (i_dut.sync !== 1'b1)
    begin
      $display("the sync pulse never came");
      abort_run();
    end
  endtask

  // waits until every framing channel has raised csn once
  task automatic wait_frames();
    int  t;
    logic done;
    t    = 0;
    done = 1'b0;
    while (!done && t < 800)
    begin
      @(negedge clk);
      t++;
      done = 1'b1;
      for (int c = 0; c < N; c++)
        if (framing[c] && model_frames[c] != frames_exp[c])
          done = 1'b0;
    end
    if (!done)
    begin
      $display("a sensor frame never ended with csn high");
      abort_run();
    end
  endtask

  task automatic wait_drain();
    int t;
    t = 0;
    while (exp_q.size() != 0 && t < 60)
    begin
      @(negedge clk);
      t++;
    end
    if (exp_q.size() != 0)
    begin
      $display("%0d expected stream bytes never arrived", exp_q.size());
      abort_run();
    end
  endtask

  // prediction at sync, following the frame rule
  task automatic start_round();
    logic [CW-1:0] tag;
    for (int c = 0; c < N; c++)
    begin
      tag = c[CW-1:0];
      if (!ds[c])
      begin
        framing[c]    = 1'b1;
        frames_exp[c] = model_frames[c] + 1;
        for (int k = 1; k < len; k++)
          if (!wide16 || !(k == 3 || k == 6 || k == 9)) // wide16 drops the third axis byte
            exp_q.push_back({tag, k == 1, base[c] + k[7:0]});
      end
      else
      begin
        framing[c] = 1'b0;
        ds[c]      = direct[c]; // idle sync may leave direct, no frame yet
      end
    end
    cmd_at_sync = cmd;
    len_at_sync = len;
  endtask

  task automatic new_config();
    rng    = xorshift(rng);
    len    = 4'd2 + 4'(rng[7:0] % 9);
    cmd    = rng[8] ? accel_pkg::CMD_READ_XYZ : rng[23:16];
    wide16 = rng[9];
  endtask

  // stream checker, samples away from the rising edge
  always @(negedge clk)
  begin : stream_mon
    int hit;
    if (rst_n === 1'b1 && stream_valid === 1'b1)
    begin
      hit = -1;
      for (int i = 0; i < exp_q.size(); i++)
        if (hit < 0 && exp_q[i][CW+8:9] == stream_chan)
          hit = i; // oldest entry of that channel
      if (hit < 0)
      begin
        $display("stream byte 0x%02h on channel %0d was not expected", stream_data, stream_chan);
        abort_run();
      end
      else
      begin
        check_byte(exp_q[hit][7:0], exp_q[hit][8], stream_data, stream_x);
        exp_q.delete(hit);
      end
    end
  end

  initial
  begin
    rst_n       = 1'b0;
    cmd         = 8'h00;
    len         = '0;
    wide16      = 1'b0;
    direct      = '0;
    direct_mosi = '0;
    direct_sclk = '0; // host keeps sclk low with csn high
    direct_csn  = '1;
    ds          = '0;
    framing     = '0;
    rng         = 32'ha47374d7;
    for (int c = 0; c < N; c++)
    begin
      rng     = xorshift(rng);
      base[c] = rng[7:0];
    end
    repeat (8) @(posedge clk);
    #2;
    rst_n = 1'b1;
    new_config();
    for (int r = 0; r < ROUNDS; r++)
    begin
      wait_sync();
      start_round();
      repeat (20) @(posedge clk);
      #2; // mid-frame, frames in flight must finish
      rng = xorshift(rng);
      if (rng[3:2] == 2'b00)
        direct[rng[1:0]] = ~direct[rng[1:0]];
      direct_mosi = rng[11:8];
      wait_frames();
      for (int c = 0; c < N; c++)
      begin
        if (framing[c])
        begin
          check_frame(c, model_cmd[c], model_count[c]);
          ds[c] = direct[c]; // taken at frame end
        end
      end
      wait_drain();
      @(posedge clk);
      #2;
      rng         = xorshift(rng);
      direct_csn  = rng[3:0];
      direct_sclk = rng[7:4] & ~rng[3:0]; // host clocks only a selected sensor
      @(negedge clk);
      check_pin("adxl_csn", (ds & direct_csn) | ~ds, adxl_csn);
      check_pin("adxl_sclk", ds & direct_sclk, adxl_sclk);
      check_pin("adxl_mosi", ds & direct_mosi, adxl_mosi);
      @(posedge clk);
      #2;
      direct_csn  = '1; // host lets go of the bus well before the next sync
      direct_sclk = '0;
      new_config();
    end
    $display("Regression passed");
    $finish;
  end

endmodule

// File: compile.f
logic/accel_pkg.sv
logic/spi_pkg.sv
logic/sample_if.sv
logic/sample_pacer.sv
logic/adxl355_reader.sv
logic/sample_merge.sv
logic/accel_array.sv
bench/adxl355_model.sv
bench/accel_array_chk.sv
bench/tb_accel_array.sv

// File: Bender.yml
package:
  name: accel_array

sources:
  - logic/accel_pkg.sv
  - logic/spi_pkg.sv
  - logic/sample_if.sv
  - logic/sample_pacer.sv
  - logic/adxl355_reader.sv
  - logic/sample_merge.sv
  - logic/accel_array.sv
  - target: test
    files:
      - bench/adxl355_model.sv
      - bench/accel_array_chk.sv
      - bench/tb_accel_array.sv
